//--- Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - include

sources:
  - hdl/cpu_isa_pkg.sv
  - hdl/cpu_uop_pkg.sv
  - hdl/ucode_rom.sv
  - hdl/ucode_sequencer.sv
  - hdl/uop_decode.sv
  - hdl/reg_file.sv
  - hdl/alu_flags.sv
  - hdl/irq_ctrl.sv
  - hdl/cpu_core.sv
  - target: test
    files:
      - tests/cpu_core_checker.sv
      - tests/cpu_core_tb.sv

//--- hdl/alu_flags.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu_flags
(
  input  cpu_isa_pkg::aluOpT aluOp,
  input  cpu_isa_pkg::byteT  regA,
  input  cpu_isa_pkg::byteT  regRd,
  input  cpu_isa_pkg::flagsT flags,
  output cpu_isa_pkg::byteT  aluResult,
  output cpu_isa_pkg::flagsT flagsNew
);
  import cpu_isa_pkg::*;

  logic [`DATA_W:0] sum;    // Carry out in the top bit
  logic [`DATA_W:0] diff;   // Borrow in the top bit
  logic [4:0]       halfSum;
  logic             negative;
  logic             half;
  logic             carry;

  assign sum     = {1'b0, regA} + {1'b0, regRd};
  assign diff    = {1'b0, regA} - {1'b0, regRd};
  assign halfSum = {1'b0, regA[3:0]} + {1'b0, regRd[3:0]};

  always_comb
  begin
    negative = 1'b0;
    half     = 1'b0;
    carry    = 1'b0;
    case (aluOp)
      ALU_ADD:
      begin
        aluResult = sum[`DATA_W-1:0];
        half      = halfSum[4];
        carry     = sum[`DATA_W];
      end
      ALU_SUB:
      begin
        aluResult = diff[`DATA_W-1:0];
        negative  = 1'b1;
        half      = (regA[3:0] < regRd[3:0]);  // Borrow from bit 4
        carry     = diff[`DATA_W];
      end
      ALU_AND:
      begin
        aluResult = regA & regRd;
        half      = 1'b1;
      end
      ALU_XOR: aluResult = regA ^ regRd;
      ALU_OR:  aluResult = regA | regRd;
      ALU_INC:
      begin
        aluResult = regRd + 1'b1;
        half      = (aluResult[3:0] == 4'h0);
        carry     = flags[`FLAG_C];          // C untouched
      end
      ALU_DEC:
      begin
        aluResult = regRd - 1'b1;
        negative  = 1'b1;
        half      = (aluResult[3:0] == 4'hF);
        carry     = flags[`FLAG_C];
      end
      default: aluResult = regRd;   // Register move
    endcase
  end

  // --------------------
  // New flags byte
  always_comb
  begin
    flagsNew = '0;
    if (aluOp == ALU_PASS)
      flagsNew = flags;
    else
    begin
      flagsNew[`FLAG_Z] = (aluResult == '0);
      flagsNew[`FLAG_N] = negative;
      flagsNew[`FLAG_H] = half;
      flagsNew[`FLAG_C] = carry;
    end
  end

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core
(
  input  logic              iClock,
  input  logic              rstN,
  input  cpu_isa_pkg::byteT iData,
  input  cpu_isa_pkg::irqT  irq,
  output cpu_isa_pkg::addrT addr,
  output cpu_isa_pkg::byteT dataOut,
  output logic              readReq,
  output logic              writeEn
);
  import cpu_isa_pkg::*;
  import cpu_uop_pkg::*;

  // --------------------
  // Sequencer side
  uPcT    uPc;
  uPcT    flowIdx;
  uopT    uop;
  logic   flowStart;
  logic   flowEnable;
  logic   pending;
  logic   condFalse;

  // --------------------
  // Datapath controls
  logic   addrHl;
  logic   regWe;
  regIdxT wrIdx;
  regIdxT rdIdx;
  aluOpT  aluOp;
  logic   useAlu;
  logic   pcInc;
  logic   pcLoadTmp;
  logic   pcLoadVec;
  logic   tmpLoLoad;
  logic   tmpHiLoad;
  logic   flagsWe;
  logic   ieSet;
  logic   ieClr;
  logic   irqAck;

  byteT   regA;
  byteT   regRd;
  byteT   aluResult;
  flagsT  flags;
  flagsT  flagsNew;
  addrT   vector;

  // The ROM decodes the opcode straight from iData
  ucode_rom       ucodeRom   (.opcode(iData), .*);
  ucode_sequencer sequencer  (.*);
  uop_decode      uopDecode  (.*);
  reg_file        regFile    (.*);
  alu_flags       aluFlags   (.*);
  irq_ctrl        irqCtrl    (.*);

endmodule

//--- hdl/cpu_isa_pkg.sv
`include "cpu_defs.svh"

package cpu_isa_pkg;

  typedef logic [`DATA_W-1:0] byteT;
  typedef logic [`ADDR_W-1:0] addrT;
  typedef logic [2:0]         regIdxT;
  typedef logic [`DATA_W-1:0] flagsT;   // Z N H C, low nibble always zero
  typedef logic [2:0]         aluOpT;
  typedef logic [`IRQ_N-1:0]  irqT;     // Bit 0 VBLANK up to bit 3 JOYPAD

  // --------------------
  // ALU operations
  localparam aluOpT ALU_ADD  = 3'd0;
  localparam aluOpT ALU_SUB  = 3'd1;
  localparam aluOpT ALU_AND  = 3'd2;
  localparam aluOpT ALU_XOR  = 3'd3;
  localparam aluOpT ALU_OR   = 3'd4;
  localparam aluOpT ALU_INC  = 3'd5;
  localparam aluOpT ALU_DEC  = 3'd6;
  localparam aluOpT ALU_PASS = 3'd7;  // LD r,r'

  // Register indices as encoded in the opcode
  localparam regIdxT REG_H = 3'd4;
  localparam regIdxT REG_L = 3'd5;
  localparam regIdxT REG_A = 3'd7;

endpackage

//--- hdl/cpu_uop_pkg.sv
`include "cpu_defs.svh"

package cpu_uop_pkg;

  typedef logic [`UPC_W-1:0] uPcT;
  typedef logic [3:0]        uCmdT;
  typedef logic [1:0]        uEndT;
  typedef logic [1:0]        uSelT;  // Bit 1 writes A, bit 0 reads the dst field

  typedef struct packed {
    uCmdT cmd;
    uEndT endMode;
    uSelT opSel;
  } uopT;

  typedef enum logic [1:0] {afterReset, startFlow, runFlow, endFlow} flowStateT;

  // --------------------
  // Micro-commands
  localparam uCmdT uNop     = 4'd0;
  localparam uCmdT uFetch   = 4'd1;   // Read at PC, PC+1
  localparam uCmdT uReadImm = 4'd2;
  localparam uCmdT uLatchLo = 4'd3;
  localparam uCmdT uLatchHi = 4'd4;
  localparam uCmdT uLoadReg = 4'd5;
  localparam uCmdT uMove    = 4'd6;
  localparam uCmdT uAlu     = 4'd7;
  localparam uCmdT uIncDec  = 4'd8;
  localparam uCmdT uStoreHl = 4'd9;
  localparam uCmdT uJump    = 4'd10;
  localparam uCmdT uCondEnd = 4'd11;  // Fetches and ends when the condition fails
  localparam uCmdT uIrqJump = 4'd12;
  localparam uCmdT uSetIe   = 4'd13;
  localparam uCmdT uClrIe   = 4'd14;

  localparam uEndT END_NONE   = 2'd0;
  localparam uEndT END_ALWAYS = 2'd1;
  localparam uEndT END_COND   = 2'd2;

  localparam uSelT SEL_DST_SRC = 2'b00;
  localparam uSelT SEL_DST_DST = 2'b01;  // INC and DEC
  localparam uSelT SEL_ACC_SRC = 2'b10;  // ALU ops into A

  // Flow start addresses in the micro-op ROM
  localparam uPcT FLOW_NOP    = 'd0;   // Also the reset flow
  localparam uPcT FLOW_LDN    = 'd1;
  localparam uPcT FLOW_MOVE   = 'd4;
  localparam uPcT FLOW_ALU    = 'd6;
  localparam uPcT FLOW_INCDEC = 'd8;
  localparam uPcT FLOW_STHL   = 'd10;
  localparam uPcT FLOW_JP     = 'd12;
  localparam uPcT FLOW_JPCC   = 'd18;
  localparam uPcT FLOW_EI     = 'd25;
  localparam uPcT FLOW_DI     = 'd27;
  localparam uPcT FLOW_IRQ    = 'd29;

endpackage

//--- hdl/irq_ctrl.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module irq_ctrl
(
  input  logic              iClock,
  input  logic              rstN,
  input  cpu_isa_pkg::irqT  irq,
  input  logic              ieSet,
  input  logic              ieClr,
  input  logic              irqAck,
  output logic              pending,
  output cpu_isa_pkg::addrT vector
);
  import cpu_isa_pkg::*;

  irqT  reqLatch;
  logic ie;   // Interrupt enable

  always_ff @(posedge iClock)
  begin
    if (!rstN)
    begin
      reqLatch <= '0;
      ie       <= 1'b0;
    end
    else
    begin
      reqLatch <= irqAck ? '0 : irq;   // Sampled every cycle
      if (irqAck || ieClr)
        ie <= 1'b0;
      else if (ieSet)
        ie <= 1'b1;
    end
  end

  assign pending = ie && (reqLatch != '0);

  // Lowest set bit wins
  always_comb
  begin
    if (reqLatch[0])
      vector = `VEC_VBLANK;
    else if (reqLatch[1])
      vector = `VEC_LCD;
    else if (reqLatch[2])
      vector = `VEC_TIMER;
    else
      vector = `VEC_JOYPAD;
  end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module reg_file
(
  input  logic                iClock,
  input  logic                rstN,
  input  logic                regWe,
  input  cpu_isa_pkg::regIdxT wrIdx,
  input  cpu_isa_pkg::regIdxT rdIdx,
  input  logic                useAlu,
  input  cpu_isa_pkg::byteT   aluResult,
  input  cpu_isa_pkg::byteT   iData,
  input  logic                pcInc,
  input  logic                pcLoadTmp,
  input  logic                pcLoadVec,
  input  cpu_isa_pkg::addrT   vector,
  input  logic                tmpLoLoad,
  input  logic                tmpHiLoad,
  input  logic                addrHl,
  input  logic                flagsWe,
  input  cpu_isa_pkg::flagsT  flagsNew,
  output cpu_isa_pkg::byteT   regA,
  output cpu_isa_pkg::byteT   regRd,
  output cpu_isa_pkg::flagsT  flags,
  output cpu_isa_pkg::addrT   addr,
  output cpu_isa_pkg::byteT   dataOut
);
  import cpu_isa_pkg::*;

  byteT regs [0:7];   // B C D E H L - A, slot 6 is never written
  addrT pc;
  addrT jumpTmp;
  byteT wrData;

  assign wrData = useAlu ? aluResult : iData;

  always_ff @(posedge iClock)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] <= '0;
    end
    else if (regWe)
      regs[wrIdx] <= wrData;
  end

  // --------------------
  // Program counter
  always_ff @(posedge iClock)
  begin
    if (!rstN)
      pc <= `RESET_PC;
    else if (pcLoadVec)
      pc <= vector;
    else if (pcLoadTmp)
      pc <= jumpTmp;
    else if (pcInc)
      pc <= pc + 1'b1;
  end

  // Jump target, low byte first
  always_ff @(posedge iClock)
  begin
    if (tmpLoLoad)
      jumpTmp[7:0] <= iData;
    if (tmpHiLoad)
      jumpTmp[15:8] <= iData;
  end

  always_ff @(posedge iClock)
  begin
    if (!rstN)
      flags <= `FLAGS_RESET;
    else if (flagsWe)
      flags <= flagsNew;
  end

  assign regA    = regs[REG_A];
  assign regRd   = regs[rdIdx];
  assign addr    = addrHl ? {regs[REG_H], regs[REG_L]} : pc;
  assign dataOut = regA;   // Only LD (HL),A writes

endmodule

//--- hdl/ucode_rom.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module ucode_rom
(
  input  cpu_isa_pkg::byteT opcode,
  input  cpu_uop_pkg::uPcT  uPc,
  output cpu_uop_pkg::uPcT  flowIdx,
  output cpu_uop_pkg::uopT  uop
);
  import cpu_uop_pkg::*;

  logic dstIsMem;
  logic srcIsMem;

  assign dstIsMem = (opcode[5:3] == 3'd6);  // (HL) operands are not kept
  assign srcIsMem = (opcode[2:0] == 3'd6);

  // --------------------
  // Opcode to flow start
  always_comb
  begin
    flowIdx = FLOW_NOP;  // NOP and unknown opcodes
    if ((opcode & `OP_DST_MASK) == `OP_LD_R_N && !dstIsMem)
      flowIdx = FLOW_LDN;
    else if (((opcode & `OP_DST_MASK) == `OP_INC_R ||
              (opcode & `OP_DST_MASK) == `OP_DEC_R) && !dstIsMem)
      flowIdx = FLOW_INCDEC;
    else if (opcode == `OP_LD_HL_A)
      flowIdx = FLOW_STHL;
    else if ((opcode & `OP_GRP_MASK) == `OP_LD_R_R && !dstIsMem && !srcIsMem)
      flowIdx = FLOW_MOVE;
    else if ((opcode & `OP_GRP_MASK) == `OP_ALU_R && !srcIsMem &&
             opcode[5:3] inside {3'd0, 3'd2, 3'd4, 3'd5, 3'd6})
      flowIdx = FLOW_ALU;     // ADD SUB AND XOR OR
    else if (opcode == `OP_JP)
      flowIdx = FLOW_JP;
    else if (opcode inside {`OP_JP_NZ, `OP_JP_Z, `OP_JP_NC, `OP_JP_C})
      flowIdx = FLOW_JPCC;
    else if (opcode == `OP_EI)
      flowIdx = FLOW_EI;
    else if (opcode == `OP_DI)
      flowIdx = FLOW_DI;
  end

  // --------------------
  // Micro-op store
  always_comb
  begin
    case (uPc)
      FLOW_NOP, FLOW_LDN + 2, FLOW_MOVE + 1, FLOW_ALU + 1, FLOW_INCDEC + 1,
      FLOW_STHL + 1, FLOW_JP + 5, FLOW_JPCC + 6, FLOW_EI + 1, FLOW_DI + 1,
      FLOW_IRQ + 1:
        uop = '{uFetch, END_ALWAYS, SEL_DST_SRC};  // Every flow ends here
      FLOW_LDN, FLOW_JP, FLOW_JP + 2, FLOW_JPCC, FLOW_JPCC + 2:
        uop = '{uReadImm, END_NONE, SEL_DST_SRC};
      FLOW_LDN + 1:    uop = '{uLoadReg, END_NONE, SEL_DST_SRC};
      FLOW_MOVE:       uop = '{uMove, END_NONE, SEL_DST_SRC};
      FLOW_ALU:        uop = '{uAlu, END_NONE, SEL_ACC_SRC};
      FLOW_INCDEC:     uop = '{uIncDec, END_NONE, SEL_DST_DST};
      FLOW_STHL:       uop = '{uStoreHl, END_NONE, SEL_DST_SRC};
      FLOW_JP + 1,
      FLOW_JPCC + 1:   uop = '{uLatchLo, END_NONE, SEL_DST_SRC};
      FLOW_JP + 3,
      FLOW_JPCC + 3:   uop = '{uLatchHi, END_NONE, SEL_DST_SRC};
      FLOW_JPCC + 4:   uop = '{uCondEnd, END_COND, SEL_DST_SRC};
      FLOW_JP + 4,
      FLOW_JPCC + 5:   uop = '{uJump, END_NONE, SEL_DST_SRC};
      FLOW_EI:         uop = '{uSetIe, END_NONE, SEL_DST_SRC};
      FLOW_DI:         uop = '{uClrIe, END_NONE, SEL_DST_SRC};
      FLOW_IRQ:        uop = '{uIrqJump, END_NONE, SEL_DST_SRC};
      default:         uop = '{uNop, END_ALWAYS, SEL_DST_SRC};
    endcase
  end

endmodule

//--- hdl/ucode_sequencer.sv
`timescale 1ns/1ps

module ucode_sequencer
(
  input  logic             iClock,
  input  logic             rstN,
  input  cpu_uop_pkg::uPcT flowIdx,
  input  logic             pending,
  input  logic             condFalse,
  input  cpu_uop_pkg::uopT uop,
  output cpu_uop_pkg::uPcT uPc,
  output logic             flowStart,
  output logic             flowEnable
);
  import cpu_uop_pkg::*;

  flowStateT state;
  flowStateT nextState;
  logic      firstFlow;  // High until the reset flow is started
  logic      endNow;
  uPcT       nextFlow;

  assign endNow = (uop.endMode == END_ALWAYS) ||
                  (uop.endMode == END_COND && condFalse);

  // Reset flow first, then a pending interrupt wins over the opcode
  always_comb
  begin
    if (firstFlow)
      nextFlow = FLOW_NOP;
    else if (pending)
      nextFlow = FLOW_IRQ;
    else
      nextFlow = flowIdx;
  end

  // --------------------
  // Flow state machine
  always_ff @(posedge iClock)
  begin
    if (!rstN)
      state <= afterReset;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      afterReset: nextState = startFlow;
      startFlow:  nextState = runFlow;
      runFlow:
        if (endNow)
          nextState = endFlow;
      endFlow:    nextState = startFlow;
      default:    nextState = afterReset;
    endcase
  end

  // --------------------
  // Micro-PC, loaded at flow start and stepped while running
  always_ff @(posedge iClock)
  begin
    if (!rstN)
    begin
      uPc       <= FLOW_NOP;
      firstFlow <= 1'b1;
    end
    else if (state == startFlow)
    begin
      uPc       <= nextFlow;
      firstFlow <= 1'b0;
    end
    else if (state == runFlow && !endNow)
      uPc <= uPc + 1'b1;
  end

  assign flowStart  = (state == startFlow);
  assign flowEnable = (state == runFlow);   // Micro-ops only act here

endmodule

//--- hdl/uop_decode.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module uop_decode
(
  input  logic                iClock,
  input  logic                rstN,
  input  cpu_uop_pkg::uopT    uop,
  input  logic                flowStart,
  input  logic                flowEnable,
  input  cpu_isa_pkg::byteT   iData,
  input  cpu_isa_pkg::flagsT  flags,
  output logic                readReq,
  output logic                writeEn,
  output logic                addrHl,
  output logic                regWe,
  output cpu_isa_pkg::regIdxT wrIdx,
  output cpu_isa_pkg::regIdxT rdIdx,
  output cpu_isa_pkg::aluOpT  aluOp,
  output logic                useAlu,
  output logic                pcInc,
  output logic                pcLoadTmp,
  output logic                pcLoadVec,
  output logic                tmpLoLoad,
  output logic                tmpHiLoad,
  output logic                flagsWe,
  output logic                ieSet,
  output logic                ieClr,
  output logic                irqAck,
  output logic                condFalse
);
  import cpu_isa_pkg::*;
  import cpu_uop_pkg::*;

  byteT opcode;
  logic condTrue;

  always_ff @(posedge iClock)
  begin
    if (!rstN)
      opcode <= `OP_NOP;
    else if (flowStart)
      opcode <= iData;  // Opcode of the flow being started
  end

  // cc field: bit 4 picks C over Z, bit 3 asks for the flag set
  assign condTrue = ((opcode[4] ? flags[`FLAG_C] : flags[`FLAG_Z]) == opcode[3]);

  assign wrIdx = uop.opSel[1] ? REG_A : opcode[5:3];
  assign rdIdx = uop.opSel[0] ? opcode[5:3] : opcode[2:0];

  always_comb
  begin
    case (uop.cmd)
      uAlu:
        case (opcode[5:3])
          3'd0:    aluOp = ALU_ADD;
          3'd2:    aluOp = ALU_SUB;
          3'd4:    aluOp = ALU_AND;
          3'd5:    aluOp = ALU_XOR;
          default: aluOp = ALU_OR;
        endcase
      uIncDec:   aluOp = opcode[0] ? ALU_DEC : ALU_INC;
      default:   aluOp = ALU_PASS;
    endcase
  end

  // --------------------
  // Bus and register controls, live only while the flow runs
  always_comb
  begin
    readReq   = 1'b0;
    writeEn   = 1'b0;
    addrHl    = 1'b0;
    regWe     = 1'b0;
    useAlu    = 1'b0;
    pcInc     = 1'b0;
    pcLoadTmp = 1'b0;
    pcLoadVec = 1'b0;
    tmpLoLoad = 1'b0;
    tmpHiLoad = 1'b0;
    flagsWe   = 1'b0;
    ieSet     = 1'b0;
    ieClr     = 1'b0;
    irqAck    = 1'b0;
    condFalse = 1'b0;
    if (flowEnable)
    begin
      case (uop.cmd)
        uFetch, uReadImm:
        begin
          readReq = 1'b1;
          pcInc   = 1'b1;
        end
        uLatchLo: tmpLoLoad = 1'b1;
        uLatchHi: tmpHiLoad = 1'b1;
        uLoadReg: regWe = 1'b1;        // Immediate byte from the bus
        uMove:
        begin
          regWe  = 1'b1;
          useAlu = 1'b1;
        end
        uAlu, uIncDec:
        begin
          regWe   = 1'b1;
          useAlu  = 1'b1;
          flagsWe = 1'b1;
        end
        uStoreHl:
        begin
          writeEn = 1'b1;
          addrHl  = 1'b1;
        end
        uJump: pcLoadTmp = 1'b1;
        uCondEnd:
        begin
          readReq   = !condTrue;       // Not taken, fetch after the operand
          pcInc     = !condTrue;
          condFalse = !condTrue;
        end
        uIrqJump:
        begin
          pcLoadVec = 1'b1;
          irqAck    = 1'b1;
        end
        uSetIe: ieSet = 1'b1;
        uClrIe: ieClr = 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and micro-address widths
`define DATA_W 8
`define ADDR_W 16
`define UPC_W  7
`define IRQ_N  4

`define RESET_PC    16'h0000
`define FLAGS_RESET 8'hB0

// Interrupt vectors in priority order
`define VEC_VBLANK 16'h0040
`define VEC_LCD    16'h0048
`define VEC_TIMER  16'h0050
`define VEC_JOYPAD 16'h0060

// --------------------
// Opcodes and opcode bases
`define OP_NOP      8'h00
`define OP_LD_R_N   8'h06  // Base, dst in bits 5:3
`define OP_INC_R    8'h04
`define OP_DEC_R    8'h05
`define OP_LD_R_R   8'h40
`define OP_ALU_R    8'h80
`define OP_LD_HL_A  8'h77
`define OP_JP       8'hC3
`define OP_JP_NZ    8'hC2
`define OP_JP_Z     8'hCA
`define OP_JP_NC    8'hD2
`define OP_JP_C     8'hDA
`define OP_EI       8'hFB
`define OP_DI       8'hF3
`define OP_DST_MASK 8'hC7  // Clears the dst field
`define OP_GRP_MASK 8'hC0

// Flag bit positions
`define FLAG_Z 7
`define FLAG_N 6
`define FLAG_H 5
`define FLAG_C 4

`endif

//--- tests/cpu_core_checker.sv
`timescale 1ns/1ps

module cpu_core_checker
(
  input logic              iClock,
  input logic              rstN,
  input logic              readReq,
  input logic              writeEn,
  input cpu_isa_pkg::addrT addr,
  input cpu_isa_pkg::byteT dataOut
);
  int   failCount = 0;
  logic resetSeen = 1'b0;   // Bus outputs are unknown before the first reset edge
  logic resetHeld = 1'b0;   // Reset was already low at the previous edge

  always @(posedge iClock)
  begin
    resetSeen <= resetSeen | !rstN;
    resetHeld <= !rstN;
  end

  // --------------------
  // Bus port rules
  noReadWrite: assert property (@(posedge iClock) resetSeen |-> !(readReq && writeEn))
    else
    begin
      failCount++;
      $error("readReq and writeEn high in the same cycle");
    end

  quietInReset: assert property (@(posedge iClock)
                                 (!rstN && resetHeld) |-> (!readReq && !writeEn))
    else
    begin
      failCount++;
      $error("bus request while reset is held");
    end

  knownWrite: assert property (@(posedge iClock)
                               (resetSeen && writeEn) |-> !$isunknown({addr, dataOut}))
    else
    begin
      failCount++;
      $error("write with unknown address or data");
    end

endmodule

bind cpu_core cpu_core_checker checker_i
(
  .iClock  (iClock),
  .rstN    (rstN),
  .readReq (readReq),
  .writeEn (writeEn),
  .addr    (addr),
  .dataOut (dataOut)
);

//--- tests/cpu_core_tb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_core_tb;
  import cpu_isa_pkg::*;

  localparam int PERIOD      = 100;
  localparam int WAIT_CYCLES = 200;   // Per wait

  logic   iClock;
  logic   rstN;
  byteT   iData;
  irqT    irq;
  addrT   addr;
  byteT   dataOut;
  logic   readReq;
  logic   writeEn;

  byteT   mem [0:65535];
  logic   rdPending;
  addrT   rdAddr;
  addrT   loadPtr;
  integer seed;
  int     errors;
  int     testErrors;
  int     testCount;
  int     assertFails;

  cpu_core cpu_core_i (.*);

  initial iClock = 1'b0;
  always #(PERIOD / 2) iClock = ~iClock;

  // --------------------
  // Memory model, bus sampled mid-cycle
  always @(negedge iClock)
  begin
    rdPending = (readReq === 1'b1);
    rdAddr    = addr;
    if (writeEn === 1'b1)
      mem[addr] = dataOut;
  end

  always @(posedge iClock)
  begin
    if (rdPending)
      #1 iData = mem[rdAddr];   // Byte of the read one cycle earlier
  end

  // --------------------
  // Reset and program loading
  task automatic holdReset;
    @(posedge iClock);
    #1 rstN = 1'b0;
    irq = '0;
    for (int a = 0; a < 65536; a++)
      mem[a] = `OP_NOP;
    loadPtr = '0;
  endtask

  task automatic releaseReset;
    repeat (4) @(posedge iClock);
    #1 rstN = 1'b1;
  endtask

  task automatic emit(input byteT b);
    mem[loadPtr] = b;
    loadPtr++;
  endtask

  task automatic emitLdImm(input regIdxT r, input byteT n);
    emit(`OP_LD_R_N | {2'b00, r, 3'b000});
    emit(n);
  endtask

  task automatic emitJp(input byteT opcode, input addrT target);
    emit(opcode);
    emit(target[7:0]);    // Low byte first
    emit(target[15:8]);
  endtask

  function automatic logic isVector(input addrT a);
    return a inside {`VEC_VBLANK, `VEC_LCD, `VEC_TIMER, `VEC_JOYPAD};
  endfunction

  // Lowest set request bit picks the vector
  function automatic addrT vectorFor(input irqT bits);
    addrT vecs [0:3];
    addrT v;
    vecs = '{`VEC_VBLANK, `VEC_LCD, `VEC_TIMER, `VEC_JOYPAD};
    v = '0;
    for (int b = 3; b >= 0; b--)
      if (bits[b])
        v = vecs[b];
    return v;
  endfunction

  // --------------------
  // Waits, each bounded by WAIT_CYCLES
  task automatic waitRead(input addrT target, output logic found);
    found = 1'b0;
    for (int i = 0; i < WAIT_CYCLES && !found; i++)
    begin
      @(negedge iClock);
      found = (readReq === 1'b1) && (addr == target);
    end
  endtask

  task automatic nextRead(output addrT seen, output logic found);
    found = 1'b0;
    seen  = '0;
    for (int i = 0; i < WAIT_CYCLES && !found; i++)
    begin
      @(negedge iClock);
      found = (readReq === 1'b1);
      seen  = addr;
    end
  endtask

  // Stops at a read of stopAt or of any vector
  task automatic scanReads(input addrT stopAt, output addrT seen, output logic atVector,
                           output logic atStop);
    atVector = 1'b0;
    atStop   = 1'b0;
    seen     = '0;
    for (int i = 0; i < WAIT_CYCLES && !atVector && !atStop; i++)
    begin
      @(negedge iClock);
      if (readReq === 1'b1)
      begin
        seen     = addr;
        atVector = isVector(addr);
        atStop   = (addr == stopAt);
      end
    end
  endtask

  // --------------------
  // Compare and report
  task automatic checkByte(input string name, input byteT expected, input byteT actual);
    if (actual !== expected)
    begin
      $display("Error %s: expected %02h, actual %02h", name, expected, actual);
      testErrors++;
    end
  endtask

  task automatic checkAddr(input string name, input addrT expected, input addrT actual);
    if (actual !== expected)
    begin
      $display("Error %s: expected %04h, actual %04h", name, expected, actual);
      testErrors++;
    end
  endtask

  task automatic reportFailure(input string name, input string what);
    $display("%s: %s", name, what);
    testErrors++;
  endtask

  task automatic finishTest(input string name);
    if (testErrors == 0)
      $display("%-12s ok", name);
    else
      $display("%-12s %0d error(s)", name, testErrors);
    errors += testErrors;
    testErrors = 0;
    testCount++;
  endtask

  task automatic expectWrite(input string name, input addrT expAddr, input byteT expData);
    logic found;
    found = 1'b0;
    for (int i = 0; i < WAIT_CYCLES && !found; i++)
    begin
      @(negedge iClock);
      found = (writeEn === 1'b1);
    end
    if (!found)
      reportFailure(name, "no memory write before the timeout");
    else
    begin
      checkAddr(name, expAddr, addr);
      checkByte(name, expData, dataOut);
    end
  endtask

  // --------------------
  // Directed tests
  task automatic testReset;
    addrT seen;
    logic found;
    holdReset();
    emit(`OP_NOP);
    emitJp(`OP_JP, loadPtr);
    fork
      releaseReset();
      repeat (4)
      begin
        @(posedge iClock);
        @(negedge iClock);
        if (readReq !== 1'b0 || writeEn !== 1'b0)
          reportFailure("reset", "bus request active while reset is held");
      end
    join
    nextRead(seen, found);
    if (!found)
      reportFailure("reset", "no read after reset before the timeout");
    else
      checkAddr("reset", `RESET_PC, seen);
    finishTest("reset");
  endtask

  task automatic testLoads;
    byteT h;
    byteT l;
    byteT a;
    h = $random(seed);
    l = $random(seed);
    a = $random(seed);
    h[7] = 1'b1;              // Write lands away from the program
    holdReset();
    emitLdImm(3'd0, a);       // B
    emitLdImm(3'd1, l);       // C
    emitLdImm(REG_H, h);
    emit(8'h69);              // LD L,C
    emit(8'h78);              // LD A,B
    emit(`OP_LD_HL_A);
    emitJp(`OP_JP, loadPtr);
    releaseReset();
    expectWrite("loads", {h, l}, a);
    finishTest("loads");
  endtask

  // fixup copies D into A after INC or DEC
  task automatic runAlu(input string name, input byteT opcode, input byteT fixup,
                        input byteT a, input byteT r, input byteT expected);
    byteT h;
    byteT l;
    h = $random(seed);
    l = $random(seed);
    h[7] = 1'b1;
    holdReset();
    emitLdImm(REG_H, h);
    emitLdImm(REG_L, l);
    emitLdImm(REG_A, a);
    emitLdImm(3'd2, r);       // D
    emit(opcode);
    emit(fixup);
    emit(`OP_LD_HL_A);
    emitJp(`OP_JP, loadPtr);
    releaseReset();
    expectWrite(name, {h, l}, expected);
    finishTest(name);
  endtask

  task automatic testAlu;
    byteT a;
    byteT r;
    for (int k = 0; k < 7; k++)
    begin
      a = $random(seed);
      r = $random(seed);
      case (k)
        0:       runAlu("ADD", 8'h82, `OP_NOP, a, r, a + r);
        1:       runAlu("SUB", 8'h92, `OP_NOP, a, r, a - r);
        2:       runAlu("AND", 8'hA2, `OP_NOP, a, r, a & r);
        3:       runAlu("XOR", 8'hAA, `OP_NOP, a, r, a ^ r);
        4:       runAlu("OR", 8'hB2, `OP_NOP, a, r, a | r);
        5:       runAlu("INC", 8'h14, 8'h7A, a, r, r + 8'd1);
        default: runAlu("DEC", 8'h15, 8'h7A, a, r, r - 8'd1);
      endcase
    end
  endtask

  task automatic runBranch(input string name, input byteT opcode, input byteT a,
                           input byteT r, input byteT jpOpcode, input logic taken);
    addrT target;
    addrT jpAt;
    addrT seen;
    logic found;
    target = $random(seed);
    target[15:12] = 4'h4;
    holdReset();
    emitLdImm(REG_A, a);
    emitLdImm(3'd2, r);
    emit(opcode);
    jpAt = loadPtr;
    emitJp(jpOpcode, target);
    releaseReset();
    waitRead(jpAt + 16'd2, found);   // High operand byte
    if (found)
      nextRead(seen, found);
    if (!found)
      reportFailure(name, "no fetch after the jump before the timeout");
    else
      checkAddr(name, taken ? target : jpAt + 16'd3, seen);
    finishTest(name);
  endtask

  task automatic testFlags;
    byteT a;
    byteT r;
    a = $random(seed);
    r = $random(seed);
    runBranch("ADD JP C", 8'h82, a, r, `OP_JP_C, (int'(a) + int'(r)) > 255);
    runBranch("ADD JP NC", 8'h82, a, r, `OP_JP_NC, (int'(a) + int'(r)) <= 255);
    runBranch("SUB JP Z", 8'h92, a, a, `OP_JP_Z, 1'b1);
    runBranch("SUB JP NZ", 8'h92, a, r, `OP_JP_NZ, a != r);
    runBranch("SUB JP C", 8'h92, a, r, `OP_JP_C, a < r);
    runBranch("AND JP Z", 8'hA2, a, ~a, `OP_JP_Z, 1'b1);
    runBranch("XOR JP NZ", 8'hAA, a, r, `OP_JP_NZ, a != r);
    runBranch("OR JP NC", 8'hB2, a, r, `OP_JP_NC, 1'b1);
    runBranch("INC JP C", 8'h14, a, r, `OP_JP_C, 1'b1);    // C kept from reset
    runBranch("DEC JP Z", 8'h15, a, 8'h01, `OP_JP_Z, 1'b1);
    runBranch("JP nn", `OP_NOP, a, r, `OP_JP, 1'b1);
  endtask

  task automatic testIrqMasked;
    addrT seen;
    logic atVector;
    logic atStop;
    holdReset();
    emit(`OP_DI);
    emit(`OP_NOP);
    emitJp(`OP_JP, loadPtr);
    releaseReset();
    irq = 4'hF;
    scanReads(16'hFFFF, seen, atVector, atStop);
    if (atVector)
      reportFailure("irq masked", "vector fetched while interrupts are disabled");
    finishTest("irq masked");
  endtask

  task automatic testIrqEnabled;
    irqT  bits;
    addrT seen;
    logic atVector;
    logic atStop;
    bits = $random(seed);
    if (bits == '0)
      bits = 4'h4;
    holdReset();
    emit(`OP_EI);
    emitJp(`OP_JP, loadPtr);
    loadPtr = `VEC_VBLANK;
    emitJp(`OP_JP, 16'h0010);   // Every handler returns to the NOP run
    loadPtr = `VEC_LCD;
    emitJp(`OP_JP, 16'h0010);
    loadPtr = `VEC_TIMER;
    emitJp(`OP_JP, 16'h0010);
    loadPtr = `VEC_JOYPAD;
    emitJp(`OP_JP, 16'h0010);
    loadPtr = 16'h0024;         // NOPs from 0x0010 up to here
    emit(`OP_EI);
    emitJp(`OP_JP, loadPtr);
    releaseReset();
    irq = bits;
    scanReads(16'hFFFF, seen, atVector, atStop);
    if (!atVector)
      reportFailure("irq enabled", "no vector fetch before the timeout");
    else
      checkAddr("irq enabled", vectorFor(bits), seen);
    finishTest("irq enabled");
  endtask

  // Continues from testIrqEnabled without a reset
  task automatic testIrqReenable;
    irqT  bits;
    addrT seen;
    logic atVector;
    logic atStop;
    bits = $random(seed);
    if (bits == '0)
      bits = 4'h2;
    @(posedge iClock);
    #1 irq = '0;
    scanReads(16'h0010, seen, atVector, atStop);
    if (!atStop)
      reportFailure("irq again", "handler did not jump back before the timeout");
    @(posedge iClock);
    #1 irq = bits;
    scanReads(16'h0024, seen, atVector, atStop);
    if (atVector)
      reportFailure("irq again", "request taken before the next EI");
    else if (!atStop)
      reportFailure("irq again", "EI not reached before the timeout");
    scanReads(16'hFFFF, seen, atVector, atStop);
    if (!atVector)
      reportFailure("irq again", "no vector fetch after EI before the timeout");
    else
      checkAddr("irq again", vectorFor(bits), seen);
    finishTest("irq again");
  endtask

  // --------------------
  initial
  begin
    rstN       = 1'b0;
    irq        = '0;
    iData      = '0;
    rdPending  = 1'b0;
    loadPtr    = '0;
    seed       = 30;
    errors     = 0;
    testErrors = 0;
    testCount  = 0;
    testReset();
    testLoads();
    testAlu();
    testFlags();
    testIrqMasked();
    testIrqEnabled();
    testIrqReenable();
    assertFails = cpu_core_i.checker_i.failCount;
    $display("%0d tests, %0d errors, %0d assertion failures", testCount, errors, assertFails);
    if (errors == 0 && assertFails == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
hdl/cpu_isa_pkg.sv
hdl/cpu_uop_pkg.sv
hdl/ucode_rom.sv
hdl/ucode_sequencer.sv
hdl/uop_decode.sv
hdl/reg_file.sv
hdl/alu_flags.sv
hdl/irq_ctrl.sv
hdl/cpu_core.sv
tests/cpu_core_checker.sv
tests/cpu_core_tb.sv
